/* filelist.f */
+incdir+hw
hw/mem_pkg.sv
hw/mem_req_arbiter.sv
hw/mem_tag_fifo.sv
hw/mem_resp_router.sv
hw/mem_subsys_top.sv
tb/mem_subsys_tb.sv

/* hw/mem_cfg.svh */
/* memory subsystem configuration
   bus, word and address widths and the in-flight request limit */

`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

//////////////////////////////////////////////////
// widths

// external and vector bus, power of two, at least 32
`define MEM_W 64

`define WORD_W 32 // scalar and instruction word

`define ADDR_W 32

//////////////////////////////////////////////////
// request tracking

// outstanding bus requests the tag buffer can hold
`define MEM_MAX_INFLIGHT 32

`endif

/* hw/mem_pkg.sv */
/* memory subsystem types
   words, enables, request sources and the response tag */

`default_nettype none

`include "mem_cfg.svh"

package mem_pkg;

    // 32-bit lanes per bus beat
    localparam int unsigned LANE_CNT = `MEM_W / 32;
    localparam int unsigned LANE_W   = (LANE_CNT > 1) ? $clog2(LANE_CNT) : 1;

    typedef logic [`ADDR_W-1:0]   addr_t;
    typedef logic [`WORD_W-1:0]   word_t;
    typedef logic [3:0]           word_be_t;
    typedef logic [`MEM_W-1:0]    mem_word_t;
    typedef logic [`MEM_W/8-1:0]  mem_be_t;
    typedef logic [LANE_W-1:0]    lane_t;

    //////////////////////////////////////////////////
    // request source and tag

    typedef enum logic [1:0] {
        SRC_FETCH  = 2'd0,
        SRC_SCALAR = 2'd1,
        SRC_VECTOR = 2'd2
    } req_src_e;

    // one entry per accepted bus request
    typedef struct packed {
        req_src_e src;
        lane_t    lane; // lane of the request address
    } mem_tag_t;

endpackage

`default_nettype wire

/* hw/mem_req_arbiter.sv */
/* request arbiter for the shared memory bus
   vector over scalar over fetch, forms the response tag */

`timescale 1ns/10ps
`default_nettype none

`include "mem_cfg.svh"

module mem_req_arbiter (
    input  wire logic                fetch_req_i,
    input  wire mem_pkg::addr_t      fetch_addr_i,
    output logic                     fetch_gnt_o,

    input  wire logic                sdata_req_i,
    input  wire logic                sdata_we_i,
    input  wire mem_pkg::addr_t      sdata_addr_i,
    input  wire mem_pkg::word_be_t   sdata_be_i,
    input  wire mem_pkg::word_t      sdata_wdata_i,
    output logic                     sdata_gnt_o,

    input  wire logic                vdata_req_i,
    input  wire logic                vdata_we_i,
    input  wire mem_pkg::addr_t      vdata_addr_i,
    input  wire mem_pkg::mem_be_t    vdata_be_i,
    input  wire mem_pkg::mem_word_t  vdata_wdata_i,
    output logic                     vdata_gnt_o,

    input  wire logic                vect_pending_load_i,
    input  wire logic                vect_pending_store_i,

    output logic                     mem_req_o,
    output logic                     mem_we_o,
    output mem_pkg::addr_t           mem_addr_o,
    output mem_pkg::mem_be_t         mem_be_o,
    output mem_pkg::mem_word_t       mem_wdata_o,

    input  wire logic                full_i,
    output logic                     push_o,
    output mem_pkg::mem_tag_t        push_tag_o
);

    // lane of a byte address within one beat
    function automatic mem_pkg::lane_t addr_lane(input mem_pkg::addr_t addr);
        if (mem_pkg::LANE_CNT > 1) begin
            return mem_pkg::lane_t'(addr >> 2);
        end
        return '0;
    endfunction

    logic           sdata_hold;
    logic           sdata_go;
    logic           data_req;
    mem_pkg::lane_t sdata_lane;

    //////////////////////////////////////////////////
    // priority and grants

    // scalar waits behind vector traffic, stores always, loads only for writes
    assign sdata_hold = vdata_req_i | vect_pending_store_i
                      | (vect_pending_load_i & sdata_we_i);
    assign sdata_go   = sdata_req_i & ~sdata_hold;
    assign data_req   = vdata_req_i | sdata_go;

    assign mem_req_o   = (data_req | fetch_req_i) & ~full_i; // no room for another tag
    assign vdata_gnt_o = vdata_req_i & ~full_i;
    assign sdata_gnt_o = sdata_go & ~full_i;
    assign fetch_gnt_o = fetch_req_i & ~data_req & ~full_i;

    assign push_o = mem_req_o;

    //////////////////////////////////////////////////
    // bus payload

    assign sdata_lane = addr_lane(sdata_addr_i);

    always_comb begin
        mem_addr_o     = fetch_addr_i;
        mem_we_o       = 1'b0; // fetch only reads
        mem_be_o       = '1;
        mem_wdata_o    = '0;
        push_tag_o.src = mem_pkg::SRC_FETCH;
        if (vdata_req_i) begin
            mem_addr_o     = vdata_addr_i;
            mem_we_o       = vdata_we_i;
            mem_be_o       = vdata_be_i;
            mem_wdata_o    = vdata_wdata_i;
            push_tag_o.src = mem_pkg::SRC_VECTOR;
        end else if (sdata_go) begin
            mem_addr_o     = sdata_addr_i;
            mem_we_o       = sdata_we_i;
            // enables move to the addressed lane, data goes to all lanes
            mem_be_o       = mem_pkg::mem_be_t'(sdata_be_i) << {sdata_lane, 2'b00};
            mem_wdata_o    = {(`MEM_W / `WORD_W){sdata_wdata_i}};
            push_tag_o.src = mem_pkg::SRC_SCALAR;
        end
        push_tag_o.lane = addr_lane(mem_addr_o);
    end

endmodule

`default_nettype wire

/* hw/mem_resp_router.sv */
/* response router for the shared memory bus
   steers each answer to its requester by the oldest tag */

`timescale 1ns/10ps
`default_nettype none

`include "mem_cfg.svh"

module mem_resp_router (
    input  wire logic                mem_rvalid_i,
    input  wire logic                mem_err_i,
    input  wire mem_pkg::mem_word_t  mem_rdata_i,

    input  wire mem_pkg::mem_tag_t   head_tag_i,
    input  wire logic                empty_i,
    output logic                     pop_o,

    output logic                     fetch_rvalid_o,
    output logic                     fetch_err_o,
    output mem_pkg::word_t           fetch_rdata_o,

    output logic                     sdata_rvalid_o,
    output logic                     sdata_err_o,
    output mem_pkg::word_t           sdata_rdata_o,

    output logic                     vdata_rvalid_o,
    output logic                     vdata_err_o,
    output mem_pkg::mem_word_t       vdata_rdata_o
);

    logic           resp_ok;
    logic           to_fetch;
    logic           to_sdata;
    logic           to_vdata;
    mem_pkg::word_t lane_word;

    // stray response with nothing outstanding is dropped
    assign resp_ok = mem_rvalid_i & ~empty_i;
    assign pop_o   = resp_ok;

    assign to_fetch = resp_ok & (head_tag_i.src == mem_pkg::SRC_FETCH);
    assign to_sdata = resp_ok & (head_tag_i.src == mem_pkg::SRC_SCALAR);
    assign to_vdata = resp_ok & (head_tag_i.src == mem_pkg::SRC_VECTOR);

    //////////////////////////////////////////////////
    // lane extraction

    assign lane_word = mem_rdata_i[head_tag_i.lane * `WORD_W +: `WORD_W];

    assign fetch_rvalid_o = to_fetch;
    assign fetch_err_o    = to_fetch & mem_err_i;
    assign fetch_rdata_o  = lane_word;

    assign sdata_rvalid_o = to_sdata;
    assign sdata_err_o    = to_sdata & mem_err_i;
    assign sdata_rdata_o  = lane_word;

    assign vdata_rvalid_o = to_vdata;
    assign vdata_err_o    = to_vdata & mem_err_i;
    assign vdata_rdata_o  = mem_rdata_i; // full beat

endmodule

`default_nettype wire

/* hw/mem_subsys_top.sv */
/* memory side of the vector coprocessor top level
   shares one external bus between fetch, scalar and vector data */

`timescale 1ns/10ps
`default_nettype none

`include "mem_cfg.svh"

module mem_subsys_top (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,

    // instruction fetch
    input  wire logic                fetch_req_i,
    input  wire mem_pkg::addr_t      fetch_addr_i,
    output logic                     fetch_gnt_o,
    output logic                     fetch_rvalid_o,
    output logic                     fetch_err_o,
    output mem_pkg::word_t           fetch_rdata_o,

    // scalar data
    input  wire logic                sdata_req_i,
    input  wire logic                sdata_we_i,
    input  wire mem_pkg::addr_t      sdata_addr_i,
    input  wire mem_pkg::word_be_t   sdata_be_i,
    input  wire mem_pkg::word_t      sdata_wdata_i,
    output logic                     sdata_gnt_o,
    output logic                     sdata_rvalid_o,
    output logic                     sdata_err_o,
    output mem_pkg::word_t           sdata_rdata_o,

    // vector data
    input  wire logic                vdata_req_i,
    input  wire logic                vdata_we_i,
    input  wire mem_pkg::addr_t      vdata_addr_i,
    input  wire mem_pkg::mem_be_t    vdata_be_i,
    input  wire mem_pkg::mem_word_t  vdata_wdata_i,
    output logic                     vdata_gnt_o,
    output logic                     vdata_rvalid_o,
    output logic                     vdata_err_o,
    output mem_pkg::mem_word_t       vdata_rdata_o,

    input  wire logic                vect_pending_load_i,
    input  wire logic                vect_pending_store_i,

    // external memory bus
    output logic                     mem_req_o,
    output logic                     mem_we_o,
    output mem_pkg::addr_t           mem_addr_o,
    output mem_pkg::mem_be_t         mem_be_o,
    output mem_pkg::mem_word_t       mem_wdata_o,
    input  wire logic                mem_rvalid_i,
    input  wire logic                mem_err_i,
    input  wire mem_pkg::mem_word_t  mem_rdata_i
);

    logic              push;
    mem_pkg::mem_tag_t push_tag;
    logic              pop;
    logic              full;
    logic              empty;
    mem_pkg::mem_tag_t head_tag;

    //////////////////////////////////////////////////
    // request side

    mem_req_arbiter u_arbiter (
        .fetch_req_i          ( fetch_req_i          ),
        .fetch_addr_i         ( fetch_addr_i         ),
        .fetch_gnt_o          ( fetch_gnt_o          ),
        .sdata_req_i          ( sdata_req_i          ),
        .sdata_we_i           ( sdata_we_i           ),
        .sdata_addr_i         ( sdata_addr_i         ),
        .sdata_be_i           ( sdata_be_i           ),
        .sdata_wdata_i        ( sdata_wdata_i        ),
        .sdata_gnt_o          ( sdata_gnt_o          ),
        .vdata_req_i          ( vdata_req_i          ),
        .vdata_we_i           ( vdata_we_i           ),
        .vdata_addr_i         ( vdata_addr_i         ),
        .vdata_be_i           ( vdata_be_i           ),
        .vdata_wdata_i        ( vdata_wdata_i        ),
        .vdata_gnt_o          ( vdata_gnt_o          ),
        .vect_pending_load_i  ( vect_pending_load_i  ),
        .vect_pending_store_i ( vect_pending_store_i ),
        .mem_req_o            ( mem_req_o            ),
        .mem_we_o             ( mem_we_o             ),
        .mem_addr_o           ( mem_addr_o           ),
        .mem_be_o             ( mem_be_o             ),
        .mem_wdata_o          ( mem_wdata_o          ),
        .full_i               ( full                 ),
        .push_o               ( push                 ),
        .push_tag_o           ( push_tag             )
    );

    // one tag per request still waiting for its answer
    mem_tag_fifo #(
        .DEPTH      ( `MEM_MAX_INFLIGHT )
    ) u_tags (
        .clk_i      ( clk_i             ),
        .rst_ni     ( rst_ni            ),
        .push_i     ( push              ),
        .push_tag_i ( push_tag          ),
        .pop_i      ( pop               ),
        .head_tag_o ( head_tag          ),
        .empty_o    ( empty             ),
        .full_o     ( full              )
    );

    //////////////////////////////////////////////////
    // response side

    mem_resp_router u_router (
        .mem_rvalid_i   ( mem_rvalid_i   ),
        .mem_err_i      ( mem_err_i      ),
        .mem_rdata_i    ( mem_rdata_i    ),
        .head_tag_i     ( head_tag       ),
        .empty_i        ( empty          ),
        .pop_o          ( pop            ),
        .fetch_rvalid_o ( fetch_rvalid_o ),
        .fetch_err_o    ( fetch_err_o    ),
        .fetch_rdata_o  ( fetch_rdata_o  ),
        .sdata_rvalid_o ( sdata_rvalid_o ),
        .sdata_err_o    ( sdata_err_o    ),
        .sdata_rdata_o  ( sdata_rdata_o  ),
        .vdata_rvalid_o ( vdata_rvalid_o ),
        .vdata_err_o    ( vdata_err_o    ),
        .vdata_rdata_o  ( vdata_rdata_o  )
    );

endmodule

`default_nettype wire

/* hw/mem_tag_fifo.sv */
/* in-order tag buffer for outstanding bus requests
   oldest tag at the head, one entry freed per response */

`timescale 1ns/10ps
`default_nettype none

module mem_tag_fifo #(
    parameter int unsigned DEPTH = 32
) (
    input  wire logic               clk_i,
    input  wire logic               rst_ni,

    input  wire logic               push_i,
    input  wire mem_pkg::mem_tag_t  push_tag_i,
    input  wire logic               pop_i,

    output mem_pkg::mem_tag_t       head_tag_o,
    output logic                    empty_o,
    output logic                    full_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    mem_pkg::mem_tag_t  tag_mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               do_push;
    logic               do_pop;

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == CNT_W'(DEPTH));
    assign head_tag_o = tag_mem[rd_ptr_q];

    //////////////////////////////////////////////////
    // pointers and count

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // push and pop together leave the count unchanged
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // tag storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            tag_mem[wr_ptr_q] <= push_tag_i;
        end
    end

endmodule

`default_nettype wire

/* tb/mem_subsys_tb.sv */
/* testbench for the memory subsystem
   random fetch, scalar and vector traffic against a bus memory model and a reference model */

`timescale 1ns/10ps
`default_nettype none

`include "mem_cfg.svh"

module mem_subsys_tb;

    localparam int unsigned BEAT_B   = `MEM_W / 8;
    localparam int unsigned BEATS    = 256 / BEAT_B; // 256-byte address window
    localparam int unsigned LANE_CNT = `MEM_W / 32;
    localparam int unsigned RUN_CYC  = 3000;
    localparam int unsigned WAIT_MAX = 300;

    logic               clk_i;
    logic               rst_ni;
    logic               fetch_req_i;
    mem_pkg::addr_t     fetch_addr_i;
    logic               fetch_gnt_o, fetch_rvalid_o, fetch_err_o;
    mem_pkg::word_t     fetch_rdata_o;
    logic               sdata_req_i, sdata_we_i;
    mem_pkg::addr_t     sdata_addr_i;
    mem_pkg::word_be_t  sdata_be_i;
    mem_pkg::word_t     sdata_wdata_i;
    logic               sdata_gnt_o, sdata_rvalid_o, sdata_err_o;
    mem_pkg::word_t     sdata_rdata_o;
    logic               vdata_req_i, vdata_we_i;
    mem_pkg::addr_t     vdata_addr_i;
    mem_pkg::mem_be_t   vdata_be_i;
    mem_pkg::mem_word_t vdata_wdata_i;
    logic               vdata_gnt_o, vdata_rvalid_o, vdata_err_o;
    mem_pkg::mem_word_t vdata_rdata_o;
    logic               vect_pending_load_i, vect_pending_store_i;
    logic               mem_req_o, mem_we_o;
    mem_pkg::addr_t     mem_addr_o;
    mem_pkg::mem_be_t   mem_be_o;
    mem_pkg::mem_word_t mem_wdata_o;
    logic               mem_rvalid_i, mem_err_i;
    mem_pkg::mem_word_t mem_rdata_i;

    logic [31:0]        lfsr_q;
    int unsigned        cyc;
    int unsigned        stall_cnt;
    int unsigned        outstanding;
    int unsigned        fill_seen;
    int unsigned        fetch_wait, sdata_wait, vdata_wait;
    logic               fetch_done, sdata_done, vdata_done;

    mem_pkg::mem_word_t bus_mem [BEATS];    // memory behind the bus
    mem_pkg::mem_word_t ref_mem [BEATS];    // reference image updated at requester side
    mem_pkg::mem_word_t rsp_data_q [$];
    logic               rsp_err_q [$];
    int unsigned        rsp_due_q [$];
    mem_pkg::req_src_e  ord_q [$];
    logic               exp_err_q [$];
    mem_pkg::word_t     fetch_exp_q [$];
    mem_pkg::word_t     sdata_exp_q [$];
    mem_pkg::mem_word_t vdata_exp_q [$];

    mem_subsys_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // random source and helpers

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic mem_pkg::mem_word_t rand_beat();
        mem_pkg::mem_word_t v;
        for (int k = 0; k < LANE_CNT; k++) begin
            v[32*k +: 32] = rand_bits(32);
        end
        return v;
    endfunction

    // every byte depends on its own address
    function automatic mem_pkg::mem_word_t fill_beat(input int unsigned beat);
        mem_pkg::mem_word_t v;
        logic [7:0]         a;
        for (int b = 0; b < BEAT_B; b++) begin
            a           = 8'(beat * BEAT_B + b);
            v[8*b +: 8] = a ^ 8'h96;
        end
        return v;
    endfunction

    task automatic fail_now();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mem_pkg::word_t expected,
                              input mem_pkg::word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            fail_now();
        end
    endtask

    task automatic check_mem_word(input string name, input mem_pkg::mem_word_t expected,
                                  input mem_pkg::mem_word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            fail_now();
        end
    endtask

    task automatic check_addr(input string name, input mem_pkg::addr_t expected,
                              input mem_pkg::addr_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            fail_now();
        end
    endtask

    task automatic check_be(input string name, input mem_pkg::mem_be_t expected,
                            input mem_pkg::mem_be_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %b actual %b", name, expected, actual);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %b actual %b at cycle %0d", name, expected, actual,
                     cyc);
            fail_now();
        end
    endtask

    task automatic count_wait(input string port, input logic waiting, inout int unsigned cnt);
        if (!waiting) begin
            cnt = 0;
        end else if (cnt == WAIT_MAX) begin
            $display("%s request was not granted within %0d cycles", port, WAIT_MAX);
            fail_now();
        end else begin
            cnt++;
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus a little after the rising edge

    task automatic drive_inputs(input logic allow_new);
        if (fetch_done) fetch_req_i = 1'b0;
        if (sdata_done) sdata_req_i = 1'b0;
        if (vdata_done) vdata_req_i = 1'b0;
        if (allow_new && !fetch_req_i && rand_bits(2) == 0) begin
            fetch_req_i  = 1'b1;
            fetch_addr_i = rand_bits(6) << 2;
        end
        if (allow_new && !sdata_req_i && rand_bits(1) != 0) begin
            sdata_req_i   = 1'b1;
            sdata_we_i    = rand_bits(1) != 0;
            sdata_addr_i  = rand_bits(6) << 2;
            sdata_be_i    = mem_pkg::word_be_t'(rand_bits(4));
            sdata_wdata_i = rand_bits(32);
        end
        if (allow_new && !vdata_req_i && rand_bits(2) == 0) begin
            vdata_req_i   = 1'b1;
            vdata_we_i    = rand_bits(1) != 0;
            vdata_addr_i  = rand_bits(8) & ~32'(BEAT_B - 1);
            vdata_be_i    = mem_pkg::mem_be_t'(rand_bits(BEAT_B));
            vdata_wdata_i = rand_beat();
        end
        vect_pending_load_i  = allow_new && rand_bits(2) == 0;
        vect_pending_store_i = allow_new && rand_bits(3) == 0;

        // bus memory model answers in order
        mem_rvalid_i = 1'b0;
        mem_err_i    = 1'b0;
        mem_rdata_i  = '0;
        if (stall_cnt > 0) begin
            stall_cnt--;
        end else if (allow_new && rand_bits(6) == 0) begin
            stall_cnt = 48; // long enough to fill the tag buffer
        end else if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
            void'(rsp_due_q.pop_front());
            mem_rvalid_i = 1'b1;
            mem_err_i    = rsp_err_q.pop_front();
            mem_rdata_i  = rsp_data_q.pop_front();
        end
    endtask

    //////////////////////////////////////////////////
    // checks at the falling edge

    task automatic check_cycle();
        logic               full;
        logic               s_go;
        logic               exp_f;
        logic               exp_s;
        logic               exp_v;
        logic               resp;
        logic               err;
        mem_pkg::req_src_e  src;
        mem_pkg::mem_be_t   exp_be;
        mem_pkg::mem_word_t exp_wdata;
        int unsigned        idx;
        int unsigned        lane;
        int                 b;

        full  = (outstanding == `MEM_MAX_INFLIGHT);
        s_go  = sdata_req_i & ~(vdata_req_i | vect_pending_store_i
                                | (vect_pending_load_i & sdata_we_i));
        exp_v = vdata_req_i & ~full;
        exp_s = s_go & ~full;
        exp_f = fetch_req_i & ~vdata_req_i & ~s_go & ~full;
        check_bit("vdata_gnt", exp_v, vdata_gnt_o);
        check_bit("sdata_gnt", exp_s, sdata_gnt_o);
        check_bit("fetch_gnt", exp_f, fetch_gnt_o);
        check_bit("mem_req", exp_v | exp_s | exp_f, mem_req_o);
        if (full) fill_seen++;
        count_wait("fetch", fetch_req_i & ~exp_f, fetch_wait);
        count_wait("scalar", sdata_req_i & ~exp_s, sdata_wait);
        count_wait("vector", vdata_req_i & ~exp_v, vdata_wait);

        // bus payload of the granted requester
        if (exp_v) begin
            check_addr("vdata_bus_addr", vdata_addr_i, mem_addr_o);
            check_bit("vdata_bus_we", vdata_we_i, mem_we_o);
            check_be("vdata_bus_be", vdata_be_i, mem_be_o);
            if (vdata_we_i) begin
                check_mem_word("vdata_bus_wdata", vdata_wdata_i, mem_wdata_o);
            end
        end else if (exp_s) begin
            lane   = (sdata_addr_i / 4) % LANE_CNT;
            exp_be = '0;
            for (b = 0; b < 4; b++) begin
                exp_be[4*lane + b] = sdata_be_i[b];
            end
            for (b = 0; b < LANE_CNT; b++) begin
                exp_wdata[32*b +: 32] = sdata_wdata_i;
            end
            check_addr("sdata_bus_addr", sdata_addr_i, mem_addr_o);
            check_bit("sdata_bus_we", sdata_we_i, mem_we_o);
            check_be("sdata_bus_be", exp_be, mem_be_o);
            if (sdata_we_i) begin
                check_mem_word("sdata_bus_wdata", exp_wdata, mem_wdata_o);
            end
        end else if (exp_f) begin
            check_addr("fetch_bus_addr", fetch_addr_i, mem_addr_o);
            check_bit("fetch_bus_we", 1'b0, mem_we_o);
        end

        resp = mem_rvalid_i;
        src  = mem_pkg::SRC_FETCH;
        err  = 1'b0;
        if (resp) begin
            src = ord_q.pop_front();
            err = exp_err_q.pop_front();
            outstanding--;
        end
        check_bit("fetch_rvalid", resp && src == mem_pkg::SRC_FETCH, fetch_rvalid_o);
        check_bit("sdata_rvalid", resp && src == mem_pkg::SRC_SCALAR, sdata_rvalid_o);
        check_bit("vdata_rvalid", resp && src == mem_pkg::SRC_VECTOR, vdata_rvalid_o);
        check_bit("fetch_err", resp && src == mem_pkg::SRC_FETCH && err, fetch_err_o);
        check_bit("sdata_err", resp && src == mem_pkg::SRC_SCALAR && err, sdata_err_o);
        check_bit("vdata_err", resp && src == mem_pkg::SRC_VECTOR && err, vdata_err_o);
        if (resp && src == mem_pkg::SRC_FETCH) begin
            check_word("fetch_rdata", fetch_exp_q.pop_front(), fetch_rdata_o);
        end else if (resp && src == mem_pkg::SRC_SCALAR) begin
            check_word("sdata_rdata", sdata_exp_q.pop_front(), sdata_rdata_o);
        end else if (resp) begin
            check_mem_word("vdata_rdata", vdata_exp_q.pop_front(), vdata_rdata_o);
        end

        // bus side accepts whatever the DUT puts on the bus
        if (mem_req_o) begin
            idx = (mem_addr_o % 256) / BEAT_B;
            for (b = 0; b < BEAT_B; b++) begin
                if (mem_we_o && mem_be_o[b]) bus_mem[idx][8*b +: 8] = mem_wdata_o[8*b +: 8];
            end
            err = (rand_bits(4) == 0); // injected bus error
            rsp_data_q.push_back(bus_mem[idx]);
            rsp_err_q.push_back(err);
            rsp_due_q.push_back(cyc + 1 + rand_bits(3) % 6);
            exp_err_q.push_back(err);
            outstanding++;
        end

        // reference model from what the requesters asked for
        if (exp_v) begin
            idx = (vdata_addr_i % 256) / BEAT_B;
            for (b = 0; b < BEAT_B; b++) begin
                if (vdata_we_i && vdata_be_i[b]) ref_mem[idx][8*b +: 8] = vdata_wdata_i[8*b +: 8];
            end
            ord_q.push_back(mem_pkg::SRC_VECTOR);
            vdata_exp_q.push_back(ref_mem[idx]);
        end else if (exp_s) begin
            idx  = (sdata_addr_i % 256) / BEAT_B;
            lane = (sdata_addr_i / 4) % LANE_CNT;
            for (b = 0; b < 4; b++) begin
                if (sdata_we_i && sdata_be_i[b]) begin
                    ref_mem[idx][32*lane + 8*b +: 8] = sdata_wdata_i[8*b +: 8];
                end
            end
            ord_q.push_back(mem_pkg::SRC_SCALAR);
            sdata_exp_q.push_back(ref_mem[idx][32*lane +: 32]);
        end else if (exp_f) begin
            idx  = (fetch_addr_i % 256) / BEAT_B;
            lane = (fetch_addr_i / 4) % LANE_CNT;
            ord_q.push_back(mem_pkg::SRC_FETCH);
            fetch_exp_q.push_back(ref_mem[idx][32*lane +: 32]);
        end
        fetch_done = exp_f;
        sdata_done = exp_s;
        vdata_done = exp_v;
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        lfsr_q               = 32'h3257_c82b;
        rst_ni               = 1'b0;
        fetch_req_i          = 1'b0;
        fetch_addr_i         = '0;
        sdata_req_i          = 1'b0;
        sdata_we_i           = 1'b0;
        sdata_addr_i         = '0;
        sdata_be_i           = '0;
        sdata_wdata_i        = '0;
        vdata_req_i          = 1'b0;
        vdata_we_i           = 1'b0;
        vdata_addr_i         = '0;
        vdata_be_i           = '0;
        vdata_wdata_i        = '0;
        vect_pending_load_i  = 1'b0;
        vect_pending_store_i = 1'b0;
        mem_rvalid_i         = 1'b0;
        mem_err_i            = 1'b0;
        mem_rdata_i          = '0;
        {fetch_done, sdata_done, vdata_done} = '0;
        {fetch_wait, sdata_wait, vdata_wait} = '0;
        stall_cnt            = 0;
        outstanding          = 0;
        fill_seen            = 0;
        for (int i = 0; i < BEATS; i++) begin
            bus_mem[i] = fill_beat(i);
            ref_mem[i] = fill_beat(i);
        end
        repeat (8) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        for (cyc = 1; cyc <= RUN_CYC; cyc++) begin
            @(posedge clk_i);
            #1 drive_inputs(1'b1);
            @(negedge clk_i);
            check_cycle();
        end

        // drain with no new requests until everything in flight is back
        for (int n = 0; n < WAIT_MAX && (ord_q.size() > 0 || fetch_req_i || sdata_req_i
                                          || vdata_req_i); n++) begin
            cyc++;
            @(posedge clk_i);
            #1 drive_inputs(1'b0);
            @(negedge clk_i);
            check_cycle();
        end
        if (ord_q.size() > 0 || fetch_req_i || sdata_req_i || vdata_req_i) begin
            $display("requests still outstanding after %0d drain cycles", WAIT_MAX);
            fail_now();
        end

        if (fill_seen == 0) begin
            $display("tag buffer never filled, back-pressure was not exercised");
            fail_now();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
